//--- design/destTarget.sv
`timescale 1ns/10ps

module destTarget (
    input  logic                  btnClk,
    input  logic                  rst,
    input  scrollsPkg::coord_t    destHPos_i,
    input  logic                  levelChange_i,
    input  scrollsPkg::coord_t    playerH_i,
    input  scrollsPkg::coord_t    playerV_i,
    output scrollsPkg::rectDesc_t dest_o,
    output logic                  levelComplete_o
);

    logic playerOnDest;

    // ====================
    // green target square
    // ====================
    always_comb begin
        dest_o.vPos   = scrollsPkg::coord_t'(scrollsPkg::DEST_VPOS);
        dest_o.hPos   = destHPos_i;
        dest_o.width  = scrollsPkg::coord_t'(scrollsPkg::CELL);
        dest_o.height = scrollsPkg::coord_t'(scrollsPkg::CELL);
        dest_o.color  = scrollsPkg::COLOR_GREEN;
    end

    assign playerOnDest = scrollsPkg::rectOverlap(playerH_i, playerV_i, dest_o);

    // ====================
    // completion flag
    // ====================
    always_ff @(posedge btnClk) begin
        if (rst) begin
            levelComplete_o <= 1'b0;
        end else if (levelChange_i) begin
            // new level starts uncompleted
            levelComplete_o <= 1'b0;
        end else if (playerOnDest) begin
            levelComplete_o <= 1'b1;
        end
        // otherwise sticky
    end

endmodule

//--- design/levelDecoder.sv
`timescale 1ns/10ps

module levelDecoder (
    input  logic                            btnClk,
    input  logic                            rst,
    input  scrollsPkg::level_t              level_i,
    output logic [scrollsPkg::NUM_ROWS-1:0] rowVisible_o,
    output scrollsPkg::coord_t              destHPos_o,
    output logic                            levelChange_o
);

    // registered level, the rest follows from it
    scrollsPkg::level_t levelQ;
    int                 destCol;

    // ====================
    // level register
    // ====================
    always_ff @(posedge btnClk) begin
        if (rst) begin
            levelQ        <= '0;
            levelChange_o <= 1'b0;
        end else begin
            levelQ        <= level_i;
            // high in the cycle the new level takes effect
            levelChange_o <= (level_i != levelQ);
        end
    end

    // ====================
    // decode
    // ====================
    always_comb begin
        if (int'(levelQ) < scrollsPkg::NUM_LEVELS) begin
            // level n opens rows 0 through n
            for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
                rowVisible_o[r] = (r <= int'(levelQ));
            end
            destCol = scrollsPkg::DEST_COL[int'(levelQ)];
        end else begin
            // fallback level, first row only
            rowVisible_o = scrollsPkg::NUM_ROWS'(1);
            destCol      = scrollsPkg::DEST_COL_FALLBACK;
        end
    end

    // column to pixel
    assign destHPos_o = scrollsPkg::coord_t'(scrollsPkg::DEST_HBASE
                                             + scrollsPkg::CELL * destCol);

endmodule

//--- design/scrollRow.sv
`timescale 1ns/10ps

module scrollRow #(
    parameter scrollsPkg::coord_t     ROW_V     = 16'd60,
    parameter scrollsPkg::coord_t     ROW_LEFT  = 16'd128,
    parameter scrollsPkg::coord_t     BAR_WIDTH = 16'd128,
    parameter scrollsPkg::coord_t     BAR_PITCH = 16'd128,
    parameter scrollsPkg::scrollDir_t DIR       = scrollsPkg::DIR_STILL,
    parameter scrollsPkg::color_t [scrollsPkg::BARS_PER_ROW-1:0] BAR_COLORS = {
        scrollsPkg::COLOR_MAGENTA, scrollsPkg::COLOR_YELLOW,
        scrollsPkg::COLOR_CYAN, scrollsPkg::COLOR_RED
    }
) (
    input  logic                                               btnClk,
    input  logic                                               rst,
    input  logic                                               visible_i,
    input  scrollsPkg::coord_t                                 playerH_i,
    input  scrollsPkg::coord_t                                 playerV_i,
    input  scrollsPkg::color_t                                 playerColor_i,
    output scrollsPkg::barState_t [scrollsPkg::BARS_PER_ROW-1:0] bars_o,
    output logic                                               blocked_o
);

    // full wrap length of the bar pattern
    localparam scrollsPkg::coord_t SPAN =
        scrollsPkg::coord_t'(scrollsPkg::BARS_PER_ROW * BAR_PITCH);

    scrollsPkg::coord_t                   hOffset;
    scrollsPkg::coord_t                   barPos [scrollsPkg::BARS_PER_ROW];
    logic [scrollsPkg::BARS_PER_ROW-1:0]  barBlocks;

    // ====================
    // offset counter
    // ====================
    always_ff @(posedge btnClk) begin
        if (rst) begin
            hOffset <= '0;
        end else if (visible_i) begin
            case (DIR)
                scrollsPkg::DIR_RIGHT: begin
                    // wrap at the end of the span
                    hOffset <= (hOffset == SPAN - 1'b1) ? '0 : hOffset + 1'b1;
                end
                scrollsPkg::DIR_LEFT: begin
                    hOffset <= (hOffset == '0) ? SPAN - 1'b1 : hOffset - 1'b1;
                end
                default: begin
                    hOffset <= hOffset;
                end
            endcase
        end
        // hidden row keeps its place
    end

    // ====================
    // bar descriptors
    // ====================
    always_comb begin
        for (int i = 0; i < scrollsPkg::BARS_PER_ROW; i++) begin
            // slot of bar i shifted by the offset, folded into the span
            barPos[i] = scrollsPkg::coord_t'(i * BAR_PITCH) + hOffset;
            if (barPos[i] >= SPAN) begin
                barPos[i] = barPos[i] - SPAN;
            end
            bars_o[i].rect.vPos   = ROW_V;
            bars_o[i].rect.hPos   = ROW_LEFT + barPos[i];
            bars_o[i].rect.width  = BAR_WIDTH;
            bars_o[i].rect.height = scrollsPkg::coord_t'(scrollsPkg::CELL);
            bars_o[i].rect.color  = BAR_COLORS[i];
            bars_o[i].hOffset     = hOffset;
            bars_o[i].visible     = visible_i;
            // same colour lets the player through
            barBlocks[i] = visible_i
                         && scrollsPkg::rectOverlap(playerH_i, playerV_i, bars_o[i].rect)
                         && (BAR_COLORS[i] != playerColor_i);
        end
    end

    assign blocked_o = |barBlocks;

endmodule

//--- design/scrolls.sv
`timescale 1ns/10ps

module scrolls #(
    // left edge of the playfield
    parameter scrollsPkg::coord_t FIELD_LEFT = 16'd128,
    // scrolling rows, one bar per pitch
    parameter scrollsPkg::coord_t WIDE_BAR   = 16'd128,
    // still bottom row, cell sized
    parameter scrollsPkg::coord_t STILL_BAR  = 16'd12
) (
    input  logic                  btnClk,
    input  logic                  rst,
    input  scrollsPkg::level_t    level_i,
    input  scrollsPkg::coord_t    playerH_i,
    input  scrollsPkg::coord_t    playerV_i,
    input  scrollsPkg::color_t    playerColor_i,
    output scrollsPkg::barState_t [scrollsPkg::NUM_ROWS-1:0][scrollsPkg::BARS_PER_ROW-1:0] bars_o,
    output logic                  playerBlocked_o,
    output scrollsPkg::rectDesc_t dest_o,
    output logic                  levelComplete_o
);

    logic [scrollsPkg::NUM_ROWS-1:0] rowVisible;
    logic [scrollsPkg::NUM_ROWS-1:0] rowBlocked;
    scrollsPkg::coord_t              destHPos;
    logic                            levelChange;

    // ====================
    // level decode
    // ====================
    levelDecoder i_levelDecoder (
        .btnClk        (btnClk),
        .rst           (rst),
        .level_i       (level_i),
        .rowVisible_o  (rowVisible),
        .destHPos_o    (destHPos),
        .levelChange_o (levelChange)
    );

    // ====================
    // scroll rows
    // ====================
    for (genvar r = 0; r < scrollsPkg::NUM_ROWS; r++) begin : gRow
        // bottom row is the short still one, shifted one cell right
        localparam bit LAST = (r == scrollsPkg::NUM_ROWS - 1);

        scrollRow #(
            .ROW_V      (scrollsPkg::coord_t'(scrollsPkg::CELL * scrollsPkg::ROW_ROW_NUM[r])),
            .ROW_LEFT   (LAST ? FIELD_LEFT + STILL_BAR : FIELD_LEFT),
            .BAR_WIDTH  (LAST ? STILL_BAR : WIDE_BAR),
            .BAR_PITCH  (LAST ? STILL_BAR : WIDE_BAR),
            .DIR        (scrollsPkg::ROW_DIR[r]),
            .BAR_COLORS (LAST ? {scrollsPkg::COLOR_RED, scrollsPkg::COLOR_YELLOW,
                                 scrollsPkg::COLOR_CYAN, scrollsPkg::COLOR_RED}
                              : {scrollsPkg::COLOR_MAGENTA, scrollsPkg::COLOR_YELLOW,
                                 scrollsPkg::COLOR_CYAN, scrollsPkg::COLOR_RED})
        ) i_scrollRow (
            .btnClk        (btnClk),
            .rst           (rst),
            .visible_i     (rowVisible[r]),
            .playerH_i     (playerH_i),
            .playerV_i     (playerV_i),
            .playerColor_i (playerColor_i),
            .bars_o        (bars_o[r]),
            .blocked_o     (rowBlocked[r])
        );
    end

    // any row can stop the player
    assign playerBlocked_o = |rowBlocked;

    // ====================
    // destination
    // ====================
    destTarget i_destTarget (
        .btnClk          (btnClk),
        .rst             (rst),
        .destHPos_i      (destHPos),
        .levelChange_i   (levelChange),
        .playerH_i       (playerH_i),
        .playerV_i       (playerV_i),
        .dest_o          (dest_o),
        .levelComplete_o (levelComplete_o)
    );

endmodule

//--- design/scrollsPkg.sv
package scrollsPkg;

    // ====================
    // geometry
    // ====================

    // all pixel coordinates share one width
    localparam int COORD_W = 16;
    typedef logic [COORD_W-1:0] coord_t;

    // grid pitch and player square side
    localparam int CELL        = 12;
    localparam int PLAYER_SIZE = 12;

    localparam int NUM_LEVELS   = 6;
    localparam int NUM_ROWS     = 6;
    localparam int BARS_PER_ROW = 4;

    // ====================
    // colours
    // ====================
    typedef logic [3:0] color_t;

    localparam color_t COLOR_RED     = 4'd2;
    localparam color_t COLOR_CYAN    = 4'd3;
    localparam color_t COLOR_YELLOW  = 4'd4;
    localparam color_t COLOR_MAGENTA = 4'd5;
    // walls, not drawn by this block
    localparam color_t COLOR_WHITE   = 4'd6;
    // destination square
    localparam color_t COLOR_GREEN   = 4'd7;

    typedef logic [2:0] level_t;

    typedef enum logic [1:0] {
        DIR_STILL,
        DIR_LEFT,
        DIR_RIGHT
    } scrollDir_t;

    // one bar or the destination, 68 bits
    typedef struct packed {
        coord_t vPos;
        coord_t hPos;
        coord_t width;
        coord_t height;
        color_t color;
    } rectDesc_t;

    // one bar as the display sees it, 85 bits
    typedef struct packed {
        rectDesc_t rect;
        coord_t    hOffset;
        logic      visible;
    } barState_t;

    // ====================
    // row and level tables
    // ====================

    // grid row of each scroll, vPos is CELL times this
    localparam int ROW_ROW_NUM [NUM_ROWS] = '{5, 10, 17, 22, 29, 34};
    localparam scrollDir_t ROW_DIR [NUM_ROWS] = '{
        DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_STILL
    };

    // destination column per level
    localparam int DEST_COL [NUM_LEVELS] = '{16, 8, 31, 2, 24, 28};
    localparam int DEST_COL_FALLBACK     = 31;
    localparam int DEST_VPOS             = 12;
    localparam int DEST_HBASE            = 128;

    // player square against a rectangle, edges exclusive
    function automatic logic rectOverlap(
        input coord_t    playerH,
        input coord_t    playerV,
        input rectDesc_t rect
    );
        logic [COORD_W:0] playerRight;
        logic [COORD_W:0] playerBottom;
        logic [COORD_W:0] rectRight;
        logic [COORD_W:0] rectBottom;
        // one extra bit so edges near the top of the range do not wrap
        playerRight  = {1'b0, playerH} + (COORD_W+1)'(PLAYER_SIZE);
        playerBottom = {1'b0, playerV} + (COORD_W+1)'(PLAYER_SIZE);
        rectRight    = {1'b0, rect.hPos} + {1'b0, rect.width};
        rectBottom   = {1'b0, rect.vPos} + {1'b0, rect.height};
        return ({1'b0, playerH} < rectRight) && (playerRight > {1'b0, rect.hPos}) &&
               ({1'b0, playerV} < rectBottom) && (playerBottom > {1'b0, rect.vPos});
    endfunction

endpackage

//--- run.sh
#!/bin/sh
# Build and run the playfield testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module scrollsTb -o scrollsSim

# tee keeps the pipeline status, the verdict comes from the log
./obj_dir/scrollsSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: testbench passed"
    exit 0
else
    echo "run.sh: testbench failed"
    exit 1
fi

//--- src.f
design/scrollsPkg.sv
design/levelDecoder.sv
design/scrollRow.sv
design/destTarget.sv
design/scrolls.sv
verification/scrollsProperties.sv
verification/scrollsTb.sv

//--- verification/scrollsProperties.sv
`timescale 1ns/10ps

module scrollsProperties (
    input logic               btnClk,
    input logic               rst,
    input scrollsPkg::level_t level_i,
    input logic               levelChange_i,
    input logic               levelComplete_i,
    input scrollsPkg::barState_t [scrollsPkg::NUM_ROWS-1:0][scrollsPkg::BARS_PER_ROW-1:0] bars_i
);

    // wide rows step 128, the still row one cell
    localparam int WIDE_SPAN  = scrollsPkg::BARS_PER_ROW * 128;
    localparam int STILL_SPAN = scrollsPkg::BARS_PER_ROW * scrollsPkg::CELL;

    // own copy of the registered level
    scrollsPkg::level_t levelSeen;

    always_ff @(posedge btnClk) begin
        if (rst) begin
            levelSeen <= '0;
        end else begin
            levelSeen <= level_i;
        end
    end

    // ====================
    // per row
    // ====================
    for (genvar r = 0; r < scrollsPkg::NUM_ROWS; r++) begin : gRow
        localparam int SPAN = (r == scrollsPkg::NUM_ROWS - 1) ? STILL_SPAN : WIDE_SPAN;

        offsetInSpan: assert property (@(posedge btnClk) int'(bars_i[r][0].hOffset) < SPAN)
            else $error("row %0d offset %0d outside span", r, bars_i[r][0].hOffset);

        hiddenAboveLevel: assert property (@(posedge btnClk) disable iff (rst)
            (r > int'(levelSeen)) |-> !bars_i[r][0].visible)
            else $error("row %0d visible above level %0d", r, levelSeen);
    end

    // flag only drops on reset or a new level
    completeHolds: assert property (@(posedge btnClk)
        $fell(levelComplete_i) |-> ($past(rst) || $past(levelChange_i)))
        else $error("levelComplete dropped without reset or level change");

endmodule

bind scrolls scrollsProperties i_props (
    .btnClk          (btnClk),
    .rst             (rst),
    .level_i         (level_i),
    .levelChange_i   (levelChange),
    .levelComplete_i (levelComplete_o),
    .bars_i          (bars_o)
);

//--- verification/scrollsTb.sv
`timescale 1ns/10ps

module scrollsTb;

    logic                  btnClk;
    logic                  rst;
    scrollsPkg::level_t    level;
    scrollsPkg::coord_t    playerH;
    scrollsPkg::coord_t    playerV;
    scrollsPkg::color_t    playerColor;
    scrollsPkg::barState_t [scrollsPkg::NUM_ROWS-1:0][scrollsPkg::BARS_PER_ROW-1:0] bars;
    logic                  playerBlocked;
    scrollsPkg::rectDesc_t dest;
    logic                  levelComplete;

    int          errorCount;
    int          testFails;
    int          testCount;
    logic [31:0] lfsr;
    // reference state stepped on the same edges as the DUT
    scrollsPkg::level_t modelLevel;
    int                 modelOff [scrollsPkg::NUM_ROWS];

    scrolls i_dut (
        .btnClk          (btnClk),
        .rst             (rst),
        .level_i         (level),
        .playerH_i       (playerH),
        .playerV_i       (playerV),
        .playerColor_i   (playerColor),
        .bars_o          (bars),
        .playerBlocked_o (playerBlocked),
        .dest_o          (dest),
        .levelComplete_o (levelComplete)
    );

    initial begin
        btnClk = 1'b0;
        forever #50 btnClk = ~btnClk;
    end

    // ====================
    // reference model
    // ====================
    function automatic bit lastRow(int r);
        return r == scrollsPkg::NUM_ROWS - 1;
    endfunction

    function automatic int pitchOf(int r);
        return lastRow(r) ? scrollsPkg::CELL : 128;
    endfunction

    function automatic int spanOf(int r);
        return scrollsPkg::BARS_PER_ROW * pitchOf(r);
    endfunction

    function automatic bit rowShown(scrollsPkg::level_t lvl, int r);
        // out of range level keeps row 0 only
        if (int'(lvl) < scrollsPkg::NUM_LEVELS) begin
            return r <= int'(lvl);
        end
        return r == 0;
    endfunction

    function automatic scrollsPkg::color_t barColor(int r, int i);
        case (i)
            0: return scrollsPkg::COLOR_RED;
            1: return scrollsPkg::COLOR_CYAN;
            2: return scrollsPkg::COLOR_YELLOW;
            default: return lastRow(r) ? scrollsPkg::COLOR_RED : scrollsPkg::COLOR_MAGENTA;
        endcase
    endfunction

    function automatic scrollsPkg::barState_t expectedBar(int r, int i);
        scrollsPkg::barState_t b;
        b.rect.vPos   = scrollsPkg::coord_t'(scrollsPkg::CELL * scrollsPkg::ROW_ROW_NUM[r]);
        b.rect.hPos   = scrollsPkg::coord_t'((lastRow(r) ? 140 : 128)
                        + (i * pitchOf(r) + modelOff[r]) % spanOf(r));
        b.rect.width  = scrollsPkg::coord_t'(pitchOf(r));
        b.rect.height = scrollsPkg::coord_t'(scrollsPkg::CELL);
        b.rect.color  = barColor(r, i);
        b.hOffset     = scrollsPkg::coord_t'(modelOff[r]);
        b.visible     = rowShown(modelLevel, r);
        return b;
    endfunction

    function automatic scrollsPkg::rectDesc_t expectedDest();
        scrollsPkg::rectDesc_t d;
        int col;
        col = (int'(modelLevel) < scrollsPkg::NUM_LEVELS) ?
              scrollsPkg::DEST_COL[int'(modelLevel)] : scrollsPkg::DEST_COL_FALLBACK;
        d.vPos   = scrollsPkg::coord_t'(scrollsPkg::DEST_VPOS);
        d.hPos   = scrollsPkg::coord_t'(scrollsPkg::DEST_HBASE + scrollsPkg::CELL * col);
        d.width  = scrollsPkg::coord_t'(scrollsPkg::CELL);
        d.height = scrollsPkg::coord_t'(scrollsPkg::CELL);
        d.color  = scrollsPkg::COLOR_GREEN;
        return d;
    endfunction

    // player square against a rectangle with far edges excluded
    function automatic bit squaresMeet(int pH, int pV, scrollsPkg::rectDesc_t q);
        return pH < int'(q.hPos) + int'(q.width) && pH + scrollsPkg::PLAYER_SIZE > int'(q.hPos)
            && pV < int'(q.vPos) + int'(q.height) && pV + scrollsPkg::PLAYER_SIZE > int'(q.vPos);
    endfunction

    function automatic bit expectedBlocked();
        scrollsPkg::barState_t b;
        bit hit;
        hit = 1'b0;
        for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
            for (int i = 0; i < scrollsPkg::BARS_PER_ROW; i++) begin
                b = expectedBar(r, i);
                if (b.visible && squaresMeet(int'(playerH), int'(playerV), b.rect)
                    && b.rect.color != playerColor) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    always @(posedge btnClk) begin
        if (rst) begin
            modelLevel <= '0;
            for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
                modelOff[r] <= 0;
            end
        end else begin
            modelLevel <= level;
            for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
                // hidden rows hold and the still row never moves
                if (rowShown(modelLevel, r) && scrollsPkg::ROW_DIR[r] == scrollsPkg::DIR_RIGHT)
                    modelOff[r] <= (modelOff[r] + 1) % spanOf(r);
                else if (rowShown(modelLevel, r) && scrollsPkg::ROW_DIR[r] == scrollsPkg::DIR_LEFT)
                    modelOff[r] <= (modelOff[r] + spanOf(r) - 1) % spanOf(r);
            end
        end
    end

    // ====================
    // helpers
    // ====================
    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic nextRandomBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int takeBits(int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(nextRandomBit());
        end
        return v;
    endfunction

    // inputs change on the falling edge only
    task automatic nextEdge();
        @(posedge btnClk);
        @(negedge btnClk);
    endtask

    // let combinational outputs follow the new inputs
    task automatic settle();
        #1;
    endtask

    task automatic checkBar(string name, scrollsPkg::barState_t exp, scrollsPkg::barState_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            testFails++;
        end
    endtask

    task automatic checkRect(string name, scrollsPkg::rectDesc_t exp, scrollsPkg::rectDesc_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            testFails++;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            testFails++;
        end
    endtask

    task automatic checkCycles(string name, int exp, int act);
        if (act != exp) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            testFails++;
        end
    endtask

    task automatic checkPlayfield(string name);
        for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
            for (int i = 0; i < scrollsPkg::BARS_PER_ROW; i++) begin
                checkBar($sformatf("%s row %0d bar %0d", name, r, i),
                         expectedBar(r, i), bars[r][i]);
            end
        end
        checkRect({name, " dest"}, expectedDest(), dest);
    endtask

    // bounded wait for the completion flag and its cycle count
    task automatic waitComplete(string name, logic want, int expCycles);
        int n;
        n = 0;
        while (levelComplete !== want && n < 8) begin
            nextEdge();
            settle();
            n++;
        end
        if (levelComplete !== want) begin
            $display("%s: levelComplete did not reach %b within 8 cycles", name, want);
            testFails++;
        end else begin
            checkCycles({name, " cycles"}, expCycles, n);
        end
    endtask

    task automatic finishTest(string name);
        $display("test %-10s %s (%0d errors)", name, testFails == 0 ? "ok" : "bad", testFails);
        errorCount += testFails;
        testFails = 0;
        testCount++;
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic testReset();
        settle();
        checkPlayfield("reset");
        checkBit("reset complete", 1'b0, levelComplete);
        checkBit("reset blocked", 1'b0, playerBlocked);
        finishTest("reset");
    endtask

    task automatic testLevels();
        int levels [7] = '{0, 1, 2, 3, 4, 5, 7};
        for (int k = 0; k < 7; k++) begin
            level = scrollsPkg::level_t'(levels[k]);
            nextEdge();
            settle();
            checkPlayfield($sformatf("level %0d", levels[k]));
        end
        finishTest("levels");
    endtask

    task automatic testScrolling();
        level = 3'd5;
        // 600 cycles wrap every moving row at least once
        for (int k = 0; k < 12; k++) begin
            repeat (50) nextEdge();
            settle();
            checkPlayfield($sformatf("scroll %0d", k));
        end
        finishTest("scrolling");
    endtask

    task automatic testBlocking();
        scrollsPkg::barState_t b;
        for (int r = 0; r < scrollsPkg::NUM_ROWS; r++) begin
            for (int i = 0; i < scrollsPkg::BARS_PER_ROW; i++) begin
                nextEdge();
                b = expectedBar(r, i);
                playerH     = b.rect.hPos;
                playerV     = b.rect.vPos;
                playerColor = b.rect.color;
                settle();
                checkBit($sformatf("match row %0d bar %0d", r, i), 1'b0, playerBlocked);
                nextEdge();
                b = expectedBar(r, i);
                playerH     = b.rect.hPos;
                // white is on no bar
                playerColor = scrollsPkg::COLOR_WHITE;
                settle();
                checkBit($sformatf("mismatch row %0d bar %0d", r, i), 1'b1, playerBlocked);
            end
        end
        for (int k = 0; k < 64; k++) begin
            nextEdge();
            playerH     = scrollsPkg::coord_t'(110 + takeBits(9));
            playerV     = scrollsPkg::coord_t'(40 + takeBits(9));
            playerColor = scrollsPkg::color_t'(2 + takeBits(2));
            settle();
            checkBit($sformatf("sweep %0d", k), expectedBlocked(), playerBlocked);
        end
        finishTest("blocking");
    endtask

    task automatic testDest();
        level   = 3'd2;
        playerH = '0;
        playerV = '0;
        repeat (2) nextEdge();
        playerH = expectedDest().hPos;
        playerV = expectedDest().vPos;
        settle();
        checkBit("dest before edge", 1'b0, levelComplete);
        waitComplete("dest set", 1'b1, 1);
        nextEdge();
        playerH = '0;
        playerV = '0;
        repeat (3) nextEdge();
        settle();
        checkBit("dest sticky", 1'b1, levelComplete);
        level = 3'd3;
        // level registers on the first edge and the flag clears on the next
        waitComplete("dest clear", 1'b0, 2);
        finishTest("dest");
    endtask

    initial begin
        rst         = 1'b1;
        level       = '0;
        playerH     = '0;
        playerV     = '0;
        playerColor = scrollsPkg::COLOR_RED;
        lfsr        = 32'he95f;
        errorCount  = 0;
        testFails   = 0;
        testCount   = 0;
        repeat (3) @(posedge btnClk);
        @(negedge btnClk);
        rst = 1'b0;
        testReset();
        testLevels();
        testScrolling();
        testBlocking();
        testDest();
        $display("%0d tests run, %0d checks failed", testCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
